//--- vlog.f
logic/cache_def.sv
logic/mem_if.sv
logic/cache_arbiter.sv
logic/icache.sv
logic/dcache.sv
logic/main_memory.sv
logic/cache_subsystem.sv
dv/tb_cache_subsystem.sv

//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - logic/cache_def.sv
  - logic/mem_if.sv
  - logic/cache_arbiter.sv
  - logic/icache.sv
  - logic/dcache.sv
  - logic/main_memory.sv
  - logic/cache_subsystem.sv
  - target: test
    files:
      - dv/tb_cache_subsystem.sv

//--- dv/tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem;
    import cache_def::*;

    localparam int WAIT_LIMIT = 200;
    localparam int MIX_OPS    = 100;

    logic  clk_i;
    logic  rst_ni;
    logic  if_req_i;
    addr_t if_addr_i;
    logic  if_ready_o;
    word_t if_rdata_o;
    logic  d_req_i;
    logic  d_we_i;
    addr_t d_addr_i;
    word_t d_wdata_i;
    logic  d_ready_o;
    word_t d_rdata_o;

    int    seed;
    int    error_cnt;
    int    timeout_cnt;
    word_t model_q [256]; // one entry per word of the 1 KiB memory.

    addr_t fetch_addr_q [MIX_OPS];
    addr_t data_addr_q  [MIX_OPS];
    logic  data_we_q    [MIX_OPS];
    word_t data_wdata_q [MIX_OPS];

    cache_subsystem cache_subsystem_inst (.*);

    always #10 clk_i = ~clk_i;

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            error_cnt++;
            $display("ERROR %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            error_cnt++;
            $display("ERROR %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // called on a falling edge, returns on the falling edge that sees ready.
    task automatic fetch(input addr_t addr);
        word_t rdata;
        logic  got;
        int    cycles;
        if_req_i  = 1'b1;
        if_addr_i = addr;
        got       = 1'b0;
        cycles    = 0;
        while (!got && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
            if (if_ready_o) begin
                got   = 1'b1;
                rdata = if_rdata_o;
            end
        end
        if_req_i = 1'b0;
        if (got) begin
            check_word("if_rdata_o", rdata, model_q[addr[9:2]]);
        end else begin
            timeout_cnt++;
            $display("fetch port hung: no ready for address 0x%08h", addr);
        end
    endtask

    task automatic data_access(input logic we, input addr_t addr, input word_t wdata);
        word_t rdata;
        logic  got;
        int    cycles;
        d_req_i   = 1'b1;
        d_we_i    = we;
        d_addr_i  = addr;
        d_wdata_i = wdata;
        got       = 1'b0;
        cycles    = 0;
        while (!got && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
            if (d_ready_o) begin
                got   = 1'b1;
                rdata = d_rdata_o;
            end
        end
        d_req_i = 1'b0;
        d_we_i  = 1'b0;
        if (!got) begin
            timeout_cnt++;
            $display("data port hung: no ready for address 0x%08h", addr);
        end else if (we) begin
            model_q[addr[9:2]] = wdata;
        end else begin
            check_word("d_rdata_o", rdata, model_q[addr[9:2]]);
        end
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        if_req_i    = 1'b0;
        if_addr_i   = '0;
        d_req_i     = 1'b0;
        d_we_i      = 1'b0;
        d_addr_i    = '0;
        d_wdata_i   = '0;
        seed        = 32'h794a2627;
        error_cnt   = 0;
        timeout_cnt = 0;
        for (int i = 0; i < 256; i++) begin
            model_q[i] = '0;
        end

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // idle ports must stay quiet.
        repeat (10) begin
            @(negedge clk_i);
            check_flag("if_ready_o", if_ready_o, 1'b0);
            check_flag("d_ready_o", d_ready_o, 1'b0);
        end

        repeat (16) begin
            data_access(1'b0, $random(seed) & 32'h3fc, '0);
        end

        for (int i = 0; i < 400; i++) begin
            data_access($random(seed) & 1, $random(seed) & 32'h3fc, $random(seed));
        end

        // 0x040 and 0x0c0 share line 4.
        for (int i = 0; i < 8; i++) begin
            data_access(1'b1, (i % 2) ? 32'h0c0 : 32'h040, $random(seed));
            data_access(1'b0, (i % 2) ? 32'h040 : 32'h0c0, '0);
        end

        for (int i = 0; i < 256; i++) begin
            fetch(i * 4);
        end

        for (int i = 0; i < MIX_OPS; i++) begin
            fetch_addr_q[i] = $random(seed) & 32'h1fc;
            data_we_q[i]    = $random(seed) & 1;
            data_addr_q[i]  = $random(seed) & 32'h3fc;
            data_wdata_q[i] = $random(seed);
            if (data_we_q[i]) begin
                data_addr_q[i] = data_addr_q[i] | 32'h200; // stores stay in the upper half.
            end
        end

        fork
            begin
                for (int i = 0; i < MIX_OPS; i++) begin
                    fetch(fetch_addr_q[i]);
                end
            end
            begin
                for (int i = 0; i < MIX_OPS; i++) begin
                    data_access(data_we_q[i], data_addr_q[i], data_wdata_q[i]);
                end
            end
        join

        repeat (8) begin
            fetch(32'h1a4);
        end

        repeat (4) @(negedge clk_i);
        $display("errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- logic/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              if_req_i,
    input  cache_def::addr_t  if_addr_i,
    output logic              if_ready_o,
    output cache_def::word_t  if_rdata_o,
    input  logic              d_req_i,
    input  logic              d_we_i,
    input  cache_def::addr_t  d_addr_i,
    input  cache_def::word_t  d_wdata_i,
    output logic              d_ready_o,
    output cache_def::word_t  d_rdata_o
);

    mem_if icache_mem ();
    mem_if dcache_mem ();
    mem_if l2_mem ();

    icache icache_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (if_req_i),
        .addr_i  (if_addr_i),
        .ready_o (if_ready_o),
        .rdata_o (if_rdata_o),
        .mem     (icache_mem.master)
    );

    dcache dcache_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (d_req_i),
        .we_i    (d_we_i),
        .addr_i  (d_addr_i),
        .wdata_i (d_wdata_i),
        .ready_o (d_ready_o),
        .rdata_o (d_rdata_o),
        .mem     (dcache_mem.master)
    );

    // one shared block port for both caches.
    cache_arbiter cache_arbiter_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .icache_mem (icache_mem.slave),
        .dcache_mem (dcache_mem.slave),
        .l2_mem     (l2_mem.master)
    );

    main_memory main_memory_inst (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .mem    (l2_mem.slave)
    );

endmodule

//--- logic/main_memory.sv
`timescale 1ns/1ps

module main_memory (
    input  logic  clk_i,
    input  logic  rst_ni,
    mem_if.slave  mem
);
    import cache_def::*;

    typedef enum logic [1:0] {MEM_IDLE, MEM_COUNT, MEM_DONE} mem_state_e;

    mem_state_e state_q;

    block_t mem_q [MEM_BLOCKS];
    logic [$clog2(MEM_LATENCY+1)-1:0] cnt_q;
    logic [$clog2(MEM_BLOCKS)-1:0]    blk_idx;
    logic   ready_q;
    block_t rdata_q;

    assign blk_idx   = mem.addr[OFFSET_BITS +: $clog2(MEM_BLOCKS)];
    assign mem.ready = ready_q;
    assign mem.rdata = rdata_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MEM_IDLE;
            cnt_q   <= '0;
            ready_q <= 1'b0;
            rdata_q <= '0;
            for (int i = 0; i < MEM_BLOCKS; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            ready_q <= 1'b0;
            unique case (state_q)
                MEM_IDLE: begin
                    if (mem.valid) begin
                        cnt_q   <= cnt_q + 1'b1; // first cycle counts.
                        state_q <= MEM_COUNT;
                    end
                end
                MEM_COUNT: begin
                    // the edge that brings the count to MEM_LATENCY.
                    if (cnt_q == MEM_LATENCY - 1) begin
                        cnt_q   <= '0;
                        ready_q <= 1'b1;
                        state_q <= MEM_DONE;
                        if (mem.rw) begin
                            mem_q[blk_idx] <= mem.data;
                        end else begin
                            rdata_q <= mem_q[blk_idx];
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                MEM_DONE: begin
                    if (!mem.valid) begin
                        state_q <= MEM_IDLE;
                    end
                end
                default: state_q <= MEM_IDLE;
            endcase
        end
    end

    a_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem.valid && (state_q != MEM_IDLE) |-> $stable(mem.addr));

endmodule

//--- logic/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  logic              we_i,
    input  cache_def::addr_t  addr_i,
    input  cache_def::word_t  wdata_i,
    output logic              ready_o,
    output cache_def::word_t  rdata_o,
    mem_if.master             mem
);
    import cache_def::*;

    typedef enum logic [1:0] {LOOKUP, FILL, WRITE, RESPOND} state_e;

    state_e state_q;

    tag_t   tag_q  [2**INDEX_BITS];
    block_t data_q [2**INDEX_BITS];
    logic [2**INDEX_BITS-1:0] line_valid_q;

    logic   mem_valid_q;
    logic   mem_rw_q;
    addr_t  mem_addr_q;
    block_t mem_data_q;

    index_t idx;
    tag_t   tag;
    logic [OFFSET_BITS-3:0] word_sel;
    word_t  line_word;
    block_t merged_line;
    logic   hit;
    logic   accept;
    logic   fill_done;
    logic   issue_write;
    logic   resp_en;

    assign idx       = addr_i[OFFSET_BITS +: INDEX_BITS];
    assign tag       = addr_i[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign word_sel  = addr_i[OFFSET_BITS-1:2];
    assign line_word = data_q[idx][word_sel*$bits(word_t) +: $bits(word_t)];
    assign hit       = line_valid_q[idx] && (tag_q[idx] == tag);

    always_comb begin
        merged_line = data_q[idx];
        merged_line[word_sel*$bits(word_t) +: $bits(word_t)] = wdata_i;
    end

    assign accept      = (state_q == LOOKUP) && req_i && !ready_o;
    assign fill_done   = (state_q == FILL) && mem.ready;
    // WRITE is entered with valid low, so the first cycle issues the block.
    assign issue_write = (state_q == WRITE) && !mem_valid_q;
    assign resp_en     = (accept && hit && !we_i) || (state_q == RESPOND);

    assign mem.valid = mem_valid_q;
    assign mem.rw    = mem_rw_q;
    assign mem.addr  = mem_addr_q;
    assign mem.data  = mem_data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= LOOKUP;
            ready_o      <= 1'b0;
            mem_valid_q  <= 1'b0;
            line_valid_q <= '0;
        end else begin
            ready_o <= 1'b0;
            unique case (state_q)
                LOOKUP: begin
                    if (accept) begin
                        if (!hit) begin
                            mem_valid_q <= 1'b1; // allocate on reads and stores.
                            state_q     <= FILL;
                        end else if (we_i) begin
                            state_q <= WRITE;
                        end else begin
                            ready_o <= 1'b1;
                        end
                    end
                end
                FILL: begin
                    if (mem.ready) begin
                        mem_valid_q       <= 1'b0;
                        line_valid_q[idx] <= 1'b1;
                        state_q           <= we_i ? WRITE : RESPOND;
                    end
                end
                WRITE: begin
                    if (!mem_valid_q) begin
                        mem_valid_q <= 1'b1;
                    end else if (mem.ready) begin
                        mem_valid_q <= 1'b0;
                        state_q     <= RESPOND;
                    end
                end
                RESPOND: begin
                    ready_o <= 1'b1;
                    state_q <= LOOKUP;
                end
                default: state_q <= LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            mem_addr_q <= {addr_i[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            mem_rw_q   <= 1'b0;
        end
        if (fill_done) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem.rdata;
        end
        if (issue_write) begin
            data_q[idx] <= merged_line; // write-through of the whole line.
            mem_rw_q    <= 1'b1;
            mem_data_q  <= merged_line;
        end
        if (resp_en) begin
            rdata_o <= line_word;
        end
    end

    a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr) && $stable(mem.data));

endmodule

//--- logic/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  cache_def::addr_t  addr_i,
    output logic              ready_o,
    output cache_def::word_t  rdata_o,
    mem_if.master             mem
);
    import cache_def::*;

    typedef enum logic [1:0] {LOOKUP, FILL, RESPOND} state_e;

    state_e state_q;

    tag_t   tag_q  [2**INDEX_BITS];
    block_t data_q [2**INDEX_BITS];
    logic [2**INDEX_BITS-1:0] line_valid_q;

    logic  mem_valid_q;
    addr_t mem_addr_q;

    index_t idx;
    tag_t   tag;
    logic [OFFSET_BITS-3:0] word_sel;
    word_t  line_word;
    logic   hit;
    logic   accept;
    logic   fill_done;
    logic   resp_en;

    assign idx       = addr_i[OFFSET_BITS +: INDEX_BITS];
    assign tag       = addr_i[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign word_sel  = addr_i[OFFSET_BITS-1:2];
    assign line_word = data_q[idx][word_sel*$bits(word_t) +: $bits(word_t)];
    assign hit       = line_valid_q[idx] && (tag_q[idx] == tag);

    // a new request is taken only while ready is low.
    assign accept    = (state_q == LOOKUP) && req_i && !ready_o;
    assign fill_done = (state_q == FILL) && mem.ready;
    assign resp_en   = (accept && hit) || (state_q == RESPOND);

    assign mem.valid = mem_valid_q;
    assign mem.rw    = 1'b0; // read only.
    assign mem.addr  = mem_addr_q;
    assign mem.data  = '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= LOOKUP;
            ready_o      <= 1'b0;
            mem_valid_q  <= 1'b0;
            line_valid_q <= '0;
        end else begin
            ready_o <= 1'b0;
            unique case (state_q)
                LOOKUP: begin
                    if (accept) begin
                        if (hit) begin
                            ready_o <= 1'b1;
                        end else begin
                            mem_valid_q <= 1'b1;
                            state_q     <= FILL;
                        end
                    end
                end
                FILL: begin
                    if (mem.ready) begin
                        mem_valid_q       <= 1'b0;
                        line_valid_q[idx] <= 1'b1;
                        state_q           <= RESPOND;
                    end
                end
                RESPOND: begin
                    ready_o <= 1'b1;
                    state_q <= LOOKUP;
                end
                default: state_q <= LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            mem_addr_q <= {addr_i[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
        if (fill_done) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem.rdata;
        end
        if (resp_en) begin
            rdata_o <= line_word;
        end
    end

    // memory requests are reads and come only from a fill.
    a_no_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem.valid |-> !mem.rw && (state_q == FILL));

endmodule

//--- logic/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter (
    input  logic   clk_i,
    input  logic   rst_ni,
    mem_if.slave   icache_mem,
    mem_if.slave   dcache_mem,
    mem_if.master  l2_mem
);
    import cache_def::*;

    typedef enum logic [1:0] {IDLE, I_CACHE, D_CACHE} arb_state_e;

    arb_state_e state_q;
    arb_state_e state_d;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (icache_mem.valid) begin
                    state_d = I_CACHE; // fetches win a tie.
                end else if (dcache_mem.valid) begin
                    state_d = D_CACHE;
                end
            end
            I_CACHE: begin
                if (!icache_mem.valid) begin
                    state_d = dcache_mem.valid ? D_CACHE : IDLE;
                end
            end
            D_CACHE: begin
                if (!dcache_mem.valid) begin
                    state_d = icache_mem.valid ? I_CACHE : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // forward the granted side, block aligned.
    always_comb begin
        l2_mem.valid     = 1'b0;
        l2_mem.rw        = 1'b0;
        l2_mem.addr      = '0;
        l2_mem.data      = '0;
        icache_mem.ready = 1'b0;
        icache_mem.rdata = '0;
        dcache_mem.ready = 1'b0;
        dcache_mem.rdata = '0;
        if (state_q == I_CACHE) begin
            l2_mem.valid     = icache_mem.valid;
            l2_mem.rw        = icache_mem.rw;
            l2_mem.addr      = {icache_mem.addr[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            l2_mem.data      = icache_mem.data;
            icache_mem.ready = l2_mem.ready;
            icache_mem.rdata = l2_mem.rdata;
        end else if (state_q == D_CACHE) begin
            l2_mem.valid     = dcache_mem.valid;
            l2_mem.rw        = dcache_mem.rw;
            l2_mem.addr      = {dcache_mem.addr[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            l2_mem.data      = dcache_mem.data;
            dcache_mem.ready = l2_mem.ready;
            dcache_mem.rdata = l2_mem.rdata;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a response only reaches the cache that is asking for it.
    a_ready_to_requester : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!icache_mem.ready || icache_mem.valid) && (!dcache_mem.ready || dcache_mem.valid));

endmodule

//--- logic/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
    import cache_def::*;

    // request side.
    logic   valid;
    logic   rw;     // 1 means write.
    addr_t  addr;
    block_t data;

    // response side, ready is a one-cycle pulse.
    logic   ready;
    block_t rdata;

    modport master (
        output valid,
        output rw,
        output addr,
        output data,
        input  ready,
        input  rdata
    );

    modport slave (
        input  valid,
        input  rw,
        input  addr,
        input  data,
        output ready,
        output rdata
    );

endinterface

//--- logic/cache_def.sv
package cache_def;

    // byte offset inside a 16-byte block.
    localparam int OFFSET_BITS = 4;

    // 8 lines per cache.
    localparam int INDEX_BITS = 3;

    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

    // main memory size in blocks, 1 KiB in total.
    localparam int MEM_BLOCKS = 64;

    // cycles from an accepted request to ready.
    localparam int MEM_LATENCY = 4;

    // byte address.
    typedef logic [31:0] addr_t;

    // cpu data word.
    typedef logic [31:0] word_t;

    // one cache line or memory block, four words.
    typedef logic [127:0] block_t;

    typedef logic [TAG_BITS-1:0] tag_t;

    typedef logic [INDEX_BITS-1:0] index_t;

endpackage
